// File: project.f
hw/axiLitePkg.sv
hw/kernelRegPkg.sv
hw/ctrlRegSelect.sv
hw/kernelCtrlReg.sv
hw/kernelArgs.sv
hw/kernelResetHandler.sv
hw/sdaKernelWrapper.sv
verification/sdaKernelWrapperTb.sv

// File: Makefile
# Verilator flow for the kernel wrapper control side.
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= sdaKernelWrapperTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

# The run passes only if the pass message shows up in the output.
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/sdaKernelWrapperTb.sv
`timescale 1ns/1ps
`default_nettype none

module sdaKernelWrapperTb
  import axiLitePkg::*;
  import kernelRegPkg::*;
();

  localparam int ClkPeriod = 40;
  localparam int NumTests = 5;
  localparam int NumArgs = 8;
  localparam int AddrWidth = 16;
  localparam logic [AddrWidth-1:0] CtrlAddr = AddrWidth'(CtrlOffset);
  localparam logic [AddrWidth-1:0] GieAddr  = AddrWidth'(GieOffset);
  localparam logic [AddrWidth-1:0] IerAddr  = AddrWidth'(IerOffset);
  localparam logic [AddrWidth-1:0] IsrAddr  = AddrWidth'(IsrOffset);
  localparam logic [AddrWidth-1:0] ArgsAddr = AddrWidth'(ArgsBase);

  logic                             apClk;
  logic                             rst;
  logic [AddrWidth-1:0]             awAddr;
  logic                             awValid;
  logic                             awReady;
  logic [AxiDataWidth-1:0]          wData;
  logic [AxiStrbWidth-1:0]          wStrb;
  logic                             wValid;
  logic                             wReady;
  axiResp                           bResp;
  logic                             bValid;
  logic                             bReady;
  logic [AddrWidth-1:0]             arAddr;
  logic                             arValid;
  logic                             arReady;
  logic [AxiDataWidth-1:0]          rData;
  axiResp                           rResp;
  logic                             rValid;
  logic                             rReady;
  logic                             argsValid;
  logic [NumArgs*AxiDataWidth-1:0]  argsData;
  logic                             argsStop;
  logic                             retValValid;
  logic                             retValStop;
  logic                             kernelRst;
  logic                             interrupt;

  logic [31:0]             seed;
  int                      errorCount;
  int                      checkCount;
  int                      startErrors;
  logic [AxiDataWidth-1:0] argsModel [NumArgs];

  sdaKernelWrapper DUT (
    .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
    .argsValid(argsValid), .argsData(argsData), .argsStop(argsStop),
    .retValValid(retValValid), .retValStop(retValStop), .kernelRst(kernelRst),
    .interrupt(interrupt), .apClk(apClk), .rst(rst)
  );

  initial begin
    apClk = 1'b0;
    forever #(ClkPeriod / 2) apClk = ~apClk;
  end

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [AddrWidth-1:0] argAddr(input int idx);
    return ArgsAddr + AddrWidth'(4 * idx);
  endfunction

  // Expected word after a write with byte strobes.
  function automatic logic [AxiDataWidth-1:0] mergeBytes(input logic [AxiDataWidth-1:0] old,
      input logic [AxiDataWidth-1:0] upd, input logic [AxiStrbWidth-1:0] strb);
    logic [AxiDataWidth-1:0] result;
    result = old;
    for (int b = 0; b < AxiStrbWidth; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = upd[b*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic checkWord(input string name, input logic [AxiDataWidth-1:0] got,
      input logic [AxiDataWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkResp(input string name, input axiResp got, input axiResp exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic nextCycle();
    @(posedge apClk);
    #1;
  endtask

  // The stall argument holds bReady low for that many cycles once bValid is up.
  task automatic axiWrite(input logic [AddrWidth-1:0] addr, input logic [AxiDataWidth-1:0] data,
      input logic [AxiStrbWidth-1:0] strb, input int stall);
    awAddr  = addr;
    awValid = 1'b1;
    wData   = data;
    wStrb   = strb;
    wValid  = 1'b1;
    @(negedge apClk);
    while (!awReady) begin
      @(negedge apClk);
    end
    checkBit("wReady", wReady, 1'b1);
    nextCycle();
    awValid = 1'b0;
    wValid  = 1'b0;
    @(negedge apClk);
    while (!bValid) begin
      @(negedge apClk);
    end
    checkResp("bResp", bResp, Okay);
    repeat (stall) begin
      nextCycle();
      @(negedge apClk);
      checkBit("bValid", bValid, 1'b1);
    end
    nextCycle();
    bReady = 1'b1;
    nextCycle();
    bReady = 1'b0;
  endtask

  // Read data must stay stable while rReady is held low.
  task automatic axiRead(input logic [AddrWidth-1:0] addr, input int stall,
      output logic [AxiDataWidth-1:0] data);
    logic [AxiDataWidth-1:0] held;
    arAddr  = addr;
    arValid = 1'b1;
    @(negedge apClk);
    while (!arReady) begin
      @(negedge apClk);
    end
    nextCycle();
    arValid = 1'b0;
    @(negedge apClk);
    while (!rValid) begin
      @(negedge apClk);
    end
    held = rData;
    checkResp("rResp", rResp, Okay);
    repeat (stall) begin
      nextCycle();
      @(negedge apClk);
      checkBit("rValid", rValid, 1'b1);
      checkWord("rData", rData, held);
    end
    nextCycle();
    rReady = 1'b1;
    nextCycle();
    rReady = 1'b0;
    data = held;
  endtask

  task automatic readExpect(input string name, input logic [AddrWidth-1:0] addr,
      input logic [AxiDataWidth-1:0] exp);
    logic [AxiDataWidth-1:0] got;
    axiRead(addr, 0, got);
    checkWord(name, got, exp);
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    if (errorCount == errorsBefore) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  task automatic testReset();
    checkBit("awReady", awReady, 1'b0);
    checkBit("wReady", wReady, 1'b0);
    checkBit("arReady", arReady, 1'b0);
    checkBit("bValid", bValid, 1'b0);
    checkBit("rValid", rValid, 1'b0);
    readExpect("ctrl", CtrlAddr, 32'h4);
    checkBit("interrupt", interrupt, 1'b0);
    checkBit("argsValid", argsValid, 1'b0);
    checkBit("kernelRst", kernelRst, 1'b1);
    checkBit("retValStop", retValStop, 1'b1);
  endtask

  task automatic testArgs();
    logic [AxiDataWidth-1:0] data;
    for (int i = 0; i < NumArgs; i++) begin
      argsModel[i] = nextRand();
      axiWrite(argAddr(i), argsModel[i], 4'hF, 0);
    end
    for (int i = 0; i < NumArgs; i++) begin
      readExpect($sformatf("args[%0d]", i), argAddr(i), argsModel[i]);
    end
    data = nextRand();
    axiWrite(argAddr(2), data, 4'b0101, 0);
    argsModel[2] = mergeBytes(argsModel[2], data, 4'b0101);
    readExpect("args[2]", argAddr(2), argsModel[2]);
    for (int i = 0; i < NumArgs; i++) begin
      checkWord($sformatf("argsData[%0d]", i), argsData[i*AxiDataWidth +: AxiDataWidth],
                argsModel[i]);
    end
    // No storage past the last argument word.
    axiWrite(argAddr(NumArgs + 1), 32'hFFFF_FFFF, 4'hF, 0);
    readExpect("args beyond count", argAddr(NumArgs + 1), 32'h0);
    // Address bits above the register window are ignored.
    readExpect("args[3] alias", argAddr(3) + 16'h0100, argsModel[3]);
    data = nextRand();
    axiWrite(argAddr(4) + 16'h0200, data, 4'hF, 0);
    argsModel[4] = data;
    readExpect("args[4]", argAddr(4), argsModel[4]);
  endtask

  task automatic testStart();
    int stall;
    axiWrite(CtrlAddr, 32'h1, 4'h1, 0);
    @(negedge apClk);
    while (kernelRst) begin
      @(negedge apClk);
    end
    while (!argsValid) begin
      @(negedge apClk);
    end
    stall = int'(nextRand() % 8) + 1;
    repeat (stall) begin
      nextCycle();
      @(negedge apClk);
      checkBit("argsValid", argsValid, 1'b1);
      checkWord("argsData[0]", argsData[AxiDataWidth-1:0], argsModel[0]);
    end
    nextCycle();
    argsStop = 1'b0;
    @(negedge apClk);
    checkBit("argsValid", argsValid, 1'b1);
    nextCycle();
    argsStop = 1'b1;
    @(negedge apClk);
    checkBit("argsValid", argsValid, 1'b0);
    checkBit("retValStop", retValStop, 1'b0);
    checkBit("kernelRst", kernelRst, 1'b0);
    nextCycle();
    readExpect("ctrl", CtrlAddr, 32'h0);
  endtask

  task automatic testDone();
    int latency;
    axiWrite(GieAddr, 32'h1, 4'hF, 0);
    axiWrite(IerAddr, 32'h1, 4'hF, 0);
    latency = int'(nextRand() % 16);
    repeat (latency) begin
      nextCycle();
    end
    checkBit("interrupt", interrupt, 1'b0);
    retValValid = 1'b1;
    nextCycle();
    retValValid = 1'b0;
    @(negedge apClk);
    checkBit("interrupt", interrupt, 1'b1);
    checkBit("kernelRst", kernelRst, 1'b1);
    checkBit("retValStop", retValStop, 1'b1);
    nextCycle();
    // First read sees done and idle, and clears done.
    readExpect("ctrl", CtrlAddr, 32'h6);
    readExpect("ctrl", CtrlAddr, 32'h4);
    axiWrite(IsrAddr, 32'h1, 4'hF, 0);
    @(negedge apClk);
    checkBit("interrupt", interrupt, 1'b0);
    nextCycle();
  endtask

  task automatic testBackpressure();
    logic [AxiDataWidth-1:0] data;
    logic [AxiDataWidth-1:0] got;
    data = nextRand();
    axiWrite(argAddr(5), data, 4'hF, int'(nextRand() % 10) + 2);
    argsModel[5] = data;
    axiRead(argAddr(5), int'(nextRand() % 10) + 2, got);
    checkWord("args[5]", got, argsModel[5]);
    readExpect("ctrl", CtrlAddr, 32'h4);
    readExpect("args[6]", argAddr(6), argsModel[6]);
  endtask

  initial begin
    seed        = 32'ha5a6_6105;
    errorCount  = 0;
    checkCount  = 0;
    rst         = 1'b1;
    awAddr      = '0;
    awValid     = 1'b0;
    wData       = '0;
    wStrb       = '0;
    wValid      = 1'b0;
    bReady      = 1'b0;
    arAddr      = '0;
    arValid     = 1'b0;
    rReady      = 1'b0;
    argsStop    = 1'b1;
    retValValid = 1'b0;
    repeat (8) begin
      @(posedge apClk);
    end
    #1;
    rst = 1'b0;
    startErrors = errorCount;
    testReset();
    finishTest("reset", startErrors);
    startErrors = errorCount;
    testArgs();
    finishTest("argument memory", startErrors);
    startErrors = errorCount;
    testStart();
    finishTest("start", startErrors);
    startErrors = errorCount;
    testDone();
    finishTest("completion and interrupt", startErrors);
    startErrors = errorCount;
    testBackpressure();
    finishTest("response back-pressure", startErrors);
    $display("Checks passed: %0d, failed: %0d", checkCount - errorCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Generous bound of 400 clock periods per test.
  initial begin
    #(NumTests * 400 * ClkPeriod);
    $display("The run timed out after %0d clock periods", NumTests * 400);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/sdaKernelWrapper.sv
`timescale 1ns/1ps
`default_nettype none

module sdaKernelWrapper
  import axiLitePkg::*;
  import kernelRegPkg::*;
#(
  parameter int KernelArgsWidth = 8,
  parameter int SlaveAddrWidth = 16
) (
  input  logic [SlaveAddrWidth-1:0]               awAddr,
  input  logic                                    awValid,
  output logic                                    awReady,
  input  logic [AxiDataWidth-1:0]                 wData,
  input  logic [AxiStrbWidth-1:0]                 wStrb,
  input  logic                                    wValid,
  output logic                                    wReady,
  output axiResp                                  bResp,
  output logic                                    bValid,
  input  logic                                    bReady,
  input  logic [SlaveAddrWidth-1:0]               arAddr,
  input  logic                                    arValid,
  output logic                                    arReady,
  output logic [AxiDataWidth-1:0]                 rData,
  output axiResp                                  rResp,
  output logic                                    rValid,
  input  logic                                    rReady,
  output logic                                    argsValid,
  output logic [KernelArgsWidth*AxiDataWidth-1:0] argsData,
  input  logic                                    argsStop,
  input  logic                                    retValValid,
  output logic                                    retValStop,
  output logic                                    kernelRst,
  output logic                                    interrupt,
  input  logic                                    apClk,
  input  logic                                    rst
);

  localparam int RegAddrWidth = argsAddrWidth(KernelArgsWidth);

  logic                    regReq;
  logic                    regWrite;
  logic [RegAddrWidth-1:0] regAddr;
  logic [AxiDataWidth-1:0] regWData;
  logic [AxiStrbWidth-1:0] regWStrb;
  logic                    regAck;
  logic [AxiDataWidth-1:0] regRData;
  logic                    ctrlAck;
  logic [AxiDataWidth-1:0] ctrlRData;
  logic                    argsAck;
  logic [AxiDataWidth-1:0] argsRData;
  logic                    goValid;
  logic                    goHoldoff;
  logic                    doneStrobe;

  // Peers drive zero when idle, so a plain OR merges them.
  assign regAck   = ctrlAck | argsAck;
  assign regRData = ctrlRData | argsRData;

  ctrlRegSelect #(
    .SlaveAddrWidth(SlaveAddrWidth),
    .RegAddrWidth(RegAddrWidth)
  ) regSelect (
    .apClk(apClk), .rst(rst),
    .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
    .regReq(regReq), .regWrite(regWrite), .regAddr(regAddr),
    .regWData(regWData), .regWStrb(regWStrb),
    .regAck(regAck), .regRData(regRData)
  );

  kernelCtrlReg #(
    .RegAddrWidth(RegAddrWidth)
  ) ctrlReg (
    .apClk(apClk), .rst(rst),
    .regReq(regReq), .regWrite(regWrite), .regAddr(regAddr),
    .regWData(regWData), .regWStrb(regWStrb),
    .regAck(ctrlAck), .regRData(ctrlRData),
    .goValid(goValid), .goHoldoff(goHoldoff), .doneStrobe(doneStrobe),
    .interrupt(interrupt)
  );

  kernelArgs #(
    .RegAddrWidth(RegAddrWidth),
    .KernelArgsWidth(KernelArgsWidth)
  ) argsMem (
    .apClk(apClk), .rst(rst),
    .regReq(regReq), .regWrite(regWrite), .regAddr(regAddr),
    .regWData(regWData), .regWStrb(regWStrb),
    .regAck(argsAck), .regRData(argsRData),
    .argsData(argsData)
  );

  kernelResetHandler resetHandler (
    .apClk(apClk), .rst(rst),
    .goValid(goValid), .goHoldoff(goHoldoff), .doneStrobe(doneStrobe),
    .argsValid(argsValid), .argsStop(argsStop),
    .retValValid(retValValid), .retValStop(retValStop),
    .kernelRst(kernelRst)
  );

endmodule

`default_nettype wire

// File: hw/kernelResetHandler.sv
`timescale 1ns/1ps
`default_nettype none

module kernelResetHandler (
  input  logic apClk,
  input  logic rst,
  input  logic goValid,
  output logic goHoldoff,
  output logic doneStrobe,
  output logic argsValid,
  input  logic argsStop,
  input  logic retValValid,
  output logic retValStop,
  output logic kernelRst
);

  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StRelease = 2'd1;
  localparam logic [1:0] StArgs    = 2'd2;
  localparam logic [1:0] StRunning = 2'd3;

  logic [1:0] state;

  // Idle, then one cycle out of reset before the arguments are offered.
  always_ff @(posedge apClk) begin
    if (rst) begin
      state <= StIdle;
    end else begin
      case (state)
        StIdle: begin
          if (goValid) begin
            state <= StRelease;
          end
        end
        StRelease: begin
          state <= StArgs;
        end
        StArgs: begin
          if (!argsStop) begin
            state <= StRunning;
          end
        end
        default: begin
          if (retValValid) begin
            state <= StIdle;
          end
        end
      endcase
    end
  end

  // The action block is held in reset whenever the kernel is idle.
  assign kernelRst  = (state == StIdle);
  assign argsValid  = (state == StArgs);
  assign retValStop = (state != StRunning);

  // Low only in the cycle the action takes the arguments.
  assign goHoldoff  = !(argsValid && !argsStop);
  assign doneStrobe = (state == StRunning) && retValValid;

endmodule

`default_nettype wire

// File: hw/kernelArgs.sv
`timescale 1ns/1ps
`default_nettype none

module kernelArgs
  import axiLitePkg::*;
  import kernelRegPkg::*;
#(
  parameter int RegAddrWidth = 7,
  parameter int KernelArgsWidth = 8
) (
  input  logic                                    apClk,
  input  logic                                    rst,
  input  logic                                    regReq,
  input  logic                                    regWrite,
  input  logic [RegAddrWidth-1:0]                 regAddr,
  input  logic [AxiDataWidth-1:0]                 regWData,
  input  logic [AxiStrbWidth-1:0]                 regWStrb,
  output logic                                    regAck,
  output logic [AxiDataWidth-1:0]                 regRData,
  output logic [KernelArgsWidth*AxiDataWidth-1:0] argsData
);

  localparam logic [RegAddrWidth-1:0] ArgsAddr = RegAddrWidth'(ArgsBase);
  localparam int IdxWidth = RegAddrWidth - 2;

  logic [AxiDataWidth-1:0] args [KernelArgsWidth];
  logic                    hit;
  logic [RegAddrWidth-1:0] offset;
  logic [IdxWidth-1:0]     wordIdx;
  logic [AxiDataWidth-1:0] rdMux;

  assign hit     = regReq && (regAddr >= ArgsAddr);
  assign offset  = regAddr - ArgsAddr;
  assign wordIdx = offset[RegAddrWidth-1:2];

  // Words past the argument count have no storage and drop writes.
  always_ff @(posedge apClk) begin
    if (rst) begin
      for (int i = 0; i < KernelArgsWidth; i++) begin
        args[i] <= '0;
      end
    end else if (hit && regWrite) begin
      for (int i = 0; i < KernelArgsWidth; i++) begin
        if (wordIdx == IdxWidth'(i)) begin
          for (int b = 0; b < AxiStrbWidth; b++) begin
            if (regWStrb[b]) begin
              args[i][b*8 +: 8] <= regWData[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  always_comb begin
    rdMux = '0;
    for (int i = 0; i < KernelArgsWidth; i++) begin
      if (wordIdx == IdxWidth'(i)) begin
        rdMux = args[i];
      end
    end
  end

  // Word 0 sits in the low bits.
  always_comb begin
    for (int i = 0; i < KernelArgsWidth; i++) begin
      argsData[i*AxiDataWidth +: AxiDataWidth] = args[i];
    end
  end

  always_ff @(posedge apClk) begin
    if (rst) begin
      regAck   <= 1'b0;
      regRData <= '0;
    end else begin
      regAck   <= hit;
      regRData <= (hit && !regWrite) ? rdMux : '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/kernelCtrlReg.sv
`timescale 1ns/1ps
`default_nettype none

module kernelCtrlReg
  import axiLitePkg::*;
  import kernelRegPkg::*;
#(
  parameter int RegAddrWidth = 7
) (
  input  logic                    apClk,
  input  logic                    rst,
  input  logic                    regReq,
  input  logic                    regWrite,
  input  logic [RegAddrWidth-1:0] regAddr,
  input  logic [AxiDataWidth-1:0] regWData,
  input  logic [AxiStrbWidth-1:0] regWStrb,
  output logic                    regAck,
  output logic [AxiDataWidth-1:0] regRData,
  output logic                    goValid,
  input  logic                    goHoldoff,
  input  logic                    doneStrobe,
  output logic                    interrupt
);

  localparam logic [RegAddrWidth-1:0] CtrlAddr = RegAddrWidth'(CtrlOffset);
  localparam logic [RegAddrWidth-1:0] GieAddr  = RegAddrWidth'(GieOffset);
  localparam logic [RegAddrWidth-1:0] IerAddr  = RegAddrWidth'(IerOffset);
  localparam logic [RegAddrWidth-1:0] IsrAddr  = RegAddrWidth'(IsrOffset);
  localparam logic [RegAddrWidth-1:0] ArgsAddr = RegAddrWidth'(ArgsBase);

  ctrlWord                 ctrl;
  ctrlWord                 wrWord;
  ctrlWord                 rdWord;
  logic                    gie;
  logic [1:0]              ier;
  logic [1:0]              isr;
  logic [1:0]              isrNext;
  logic                    hit;
  logic                    wrLow;
  logic                    accepted;
  logic [AxiDataWidth-1:0] rdMux;

  // This block answers everything below the argument window.
  assign hit = regReq && (regAddr < ArgsAddr);

  // All run/status fields live in byte lane 0.
  assign wrLow = hit && regWrite && regWStrb[0];

  assign wrWord.raw = regWData;
  assign goValid    = ctrl.bits.apStart;
  assign accepted   = ctrl.bits.apStart && !goHoldoff;

  always_ff @(posedge apClk) begin
    if (rst) begin
      // Kernel comes out of reset idle.
      ctrl.raw         <= '0;
      ctrl.bits.apIdle <= 1'b1;
      gie              <= 1'b0;
      ier              <= '0;
      isr              <= '0;
    end else begin
      if (accepted) begin
        ctrl.bits.apStart <= 1'b0;
        ctrl.bits.apIdle  <= 1'b0;
      end
      if (wrLow && (regAddr == CtrlAddr) && wrWord.bits.apStart) begin
        ctrl.bits.apStart <= 1'b1;
      end
      // Reading the control word acknowledges a finished run.
      if (hit && !regWrite && (regAddr == CtrlAddr)) begin
        ctrl.bits.apDone <= 1'b0;
      end
      if (doneStrobe) begin
        ctrl.bits.apDone <= 1'b1;
        ctrl.bits.apIdle <= 1'b1;
      end
      if (wrLow && (regAddr == GieAddr)) begin
        gie <= regWData[0];
      end
      if (wrLow && (regAddr == IerAddr)) begin
        ier <= regWData[1:0];
      end
      isr <= isrNext;
    end
  end

  // Host writes toggle isr bits.
  // Bit 0 flags done and bit 1 flags ready.
  always_comb begin
    isrNext = isr;
    if (wrLow && (regAddr == IsrAddr)) begin
      isrNext = isrNext ^ regWData[1:0];
    end
    isrNext = isrNext | {accepted, doneStrobe};
  end

  always_comb begin
    rdWord.raw          = '0;
    rdWord.bits.apStart = ctrl.bits.apStart;
    rdWord.bits.apDone  = ctrl.bits.apDone;
    rdWord.bits.apIdle  = ctrl.bits.apIdle;
    rdWord.bits.apReady = accepted;
    case (regAddr)
      CtrlAddr: rdMux = rdWord.raw;
      GieAddr:  rdMux = AxiDataWidth'(gie);
      IerAddr:  rdMux = AxiDataWidth'(ier);
      IsrAddr:  rdMux = AxiDataWidth'(isr);
      default:  rdMux = '0;
    endcase
  end

  // Ack and data come one cycle after the request and are zero otherwise.
  always_ff @(posedge apClk) begin
    if (rst) begin
      regAck   <= 1'b0;
      regRData <= '0;
    end else begin
      regAck   <= hit;
      regRData <= (hit && !regWrite) ? rdMux : '0;
    end
  end

  // Only the done interrupt reaches the host line.
  assign interrupt = gie && ier[0] && isr[0];

endmodule

`default_nettype wire

// File: hw/ctrlRegSelect.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlRegSelect
  import axiLitePkg::*;
#(
  parameter int SlaveAddrWidth = 16,
  parameter int RegAddrWidth = 7
) (
  input  logic                      apClk,
  input  logic                      rst,
  input  logic [SlaveAddrWidth-1:0] awAddr,
  input  logic                      awValid,
  output logic                      awReady,
  input  logic [AxiDataWidth-1:0]   wData,
  input  logic [AxiStrbWidth-1:0]   wStrb,
  input  logic                      wValid,
  output logic                      wReady,
  output axiResp                    bResp,
  output logic                      bValid,
  input  logic                      bReady,
  input  logic [SlaveAddrWidth-1:0] arAddr,
  input  logic                      arValid,
  output logic                      arReady,
  output logic [AxiDataWidth-1:0]   rData,
  output axiResp                    rResp,
  output logic                      rValid,
  input  logic                      rReady,
  output logic                      regReq,
  output logic                      regWrite,
  output logic [RegAddrWidth-1:0]   regAddr,
  output logic [AxiDataWidth-1:0]   regWData,
  output logic [AxiStrbWidth-1:0]   regWStrb,
  input  logic                      regAck,
  input  logic [AxiDataWidth-1:0]   regRData
);

  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StRequest = 2'd1;
  localparam logic [1:0] StWaitAck = 2'd2;
  localparam logic [1:0] StRespond = 2'd3;

  logic [1:0]              state;
  logic                    isWrite;
  logic                    wrPending;
  logic                    wrGrant;
  logic                    rdGrant;
  logic                    respTaken;
  logic [RegAddrWidth-1:0] addrQ;
  logic [AxiDataWidth-1:0] wDataQ;
  logic [AxiStrbWidth-1:0] wStrbQ;
  logic [AxiDataWidth-1:0] rDataQ;

  // A write is only taken once both its address and its data are present.
  assign wrPending = awValid && wValid;

  // Writes win when both channels wait.
  assign wrGrant = (state == StIdle) && wrPending;
  assign rdGrant = (state == StIdle) && arValid && !wrPending;

  assign awReady = wrGrant;
  assign wReady  = wrGrant;
  assign arReady = rdGrant;

  assign respTaken = isWrite ? bReady : rReady;

  always_ff @(posedge apClk) begin
    if (rst) begin
      state   <= StIdle;
      isWrite <= 1'b0;
    end else begin
      case (state)
        StIdle: begin
          if (wrGrant || rdGrant) begin
            state   <= StRequest;
            isWrite <= wrGrant;
          end
        end
        StRequest: begin
          state <= StWaitAck;
        end
        StWaitAck: begin
          if (regAck) begin
            state <= StRespond;
          end
        end
        default: begin
          if (respTaken) begin
            state <= StIdle;
          end
        end
      endcase
    end
  end

  // Upper address bits are dropped here, so the register map aliases.
  always_ff @(posedge apClk) begin
    if (wrGrant) begin
      addrQ  <= awAddr[RegAddrWidth-1:0];
      wDataQ <= wData;
      wStrbQ <= wStrb;
    end else if (rdGrant) begin
      addrQ <= arAddr[RegAddrWidth-1:0];
    end
    if ((state == StWaitAck) && regAck) begin
      rDataQ <= regRData;
    end
  end

  // One strobe per transaction on the register bus.
  assign regReq   = (state == StRequest);
  assign regWrite = isWrite;
  assign regAddr  = addrQ;
  assign regWData = wDataQ;
  assign regWStrb = wStrbQ;

  // Responses hold until the host takes them.
  assign bValid = (state == StRespond) && isWrite;
  assign rValid = (state == StRespond) && !isWrite;
  assign bResp  = Okay;
  assign rResp  = Okay;
  assign rData  = rDataQ;

endmodule

`default_nettype wire

// File: hw/kernelRegPkg.sv
`default_nettype none

package kernelRegPkg;

  // Run/status register offsets.
  localparam int unsigned CtrlOffset = 'h00;
  localparam int unsigned GieOffset  = 'h04;
  localparam int unsigned IerOffset  = 'h08;
  localparam int unsigned IsrOffset  = 'h0C;

  // Kernel argument memory starts here.
  localparam int unsigned ArgsBase = 'h40;

  // Control word fields with apStart in bit 0.
  typedef struct packed {
    logic [27:0] reserved;
    logic        apReady;
    logic        apIdle;
    logic        apDone;
    logic        apStart;
  } ctrlBits;

  // Written by the host as a raw word, read back as fields.
  typedef union packed {
    ctrlBits     bits;
    logic [31:0] raw;
  } ctrlWord;

  // Register address width needed to reach all argument words.
  // The argument window spans ArgsBase up to the top of the address space.
  function automatic int argsAddrWidth(input int argsCount);
    if (argsCount <= 16) begin
      return 7;
    end else if (argsCount <= 48) begin
      return 8;
    end
    return 9;
  endfunction

endpackage

`default_nettype wire

// File: hw/axiLitePkg.sv
`default_nettype none

package axiLitePkg;

  // Width of the control data bus.
  localparam int AxiDataWidth = 32;

  // One write strobe per byte lane.
  localparam int AxiStrbWidth = AxiDataWidth / 8;

  // Response codes on the B and R channels.
  // The control slave only ever answers Okay.
  typedef enum logic [1:0] {
    Okay   = 2'b00,
    SlvErr = 2'b10
  } axiResp;

endpackage

`default_nettype wire
